/* hdl/cdc_consts.svh */
// CDC bridge constants

`ifndef CDC_CONSTS_SVH
`define CDC_CONSTS_SVH

// ----------------------------------------------------------
// Datapath sizing
// ----------------------------------------------------------

// Operand, accumulator and event counter width
`define CDC_DATA_W 16

// Flop depth of every synchronizer chain, 2 to 4 is sensible
`define CDC_SYNC_STAGES 3

// Opcode width, four commands
`define CDC_OP_W 2

`endif

/* hdl/cdc_pkg.sv */
// CDC bridge types
`default_nettype none

`include "cdc_consts.svh"

package cdc_pkg;

    // Command opcodes applied to the accumulator
    typedef enum logic [`CDC_OP_W-1:0] {
        OP_LOAD  = 2'd0,
        OP_ADD   = 2'd1,
        OP_XOR   = 2'd2,
        OP_CLEAR = 2'd3
    } cdc_op_e;

    // Source side request states
    typedef enum logic [1:0] {
        L_IDLE         = 2'd0,
        L_REQ          = 2'd1,
        L_WAIT_ACK_LOW = 2'd2
    } launch_state_e;

    // Destination side acknowledge states
    typedef enum logic {
        E_IDLE = 1'b0,
        E_ACK  = 1'b1
    } exec_state_e;

endpackage

`default_nettype wire

/* hdl/reset_sync.sv */
// Domain reset synchronizer
`timescale 1ns/1ps
`default_nettype none

`include "cdc_consts.svh"

module reset_sync (
    input  logic i_clk,
    input  logic i_arst_n,
    output logic o_rst_n
);

    // ----------------------------------------------------------
    // Release chain
    // ----------------------------------------------------------

    // Ones shift in after reset lifts
    logic [`CDC_SYNC_STAGES-1:0] r_chain;

    // Clear at once on assert, fill on the local clock
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_chain <= '0;
        end else begin
            r_chain <= {r_chain[`CDC_SYNC_STAGES-2:0], 1'b1};
        end
    end

    // Last stage is the clean domain reset
    assign o_rst_n = r_chain[`CDC_SYNC_STAGES-1];

endmodule

`default_nettype wire

/* hdl/sync_pulse.sv */
// Toggle pulse synchronizer
`timescale 1ns/1ps
`default_nettype none

`include "cdc_consts.svh"

// SYNC_STAGES must lie between 2 and 4
// Source pulses need 3 dst plus 2 src cycles of spacing
module sync_pulse #(
    parameter int SYNC_STAGES = `CDC_SYNC_STAGES
) (
    // Source side
    input  logic i_src_clk,
    input  logic i_src_rst_n,
    input  logic i_pulse,

    // Destination side
    input  logic i_dst_clk,
    input  logic i_dst_rst_n,
    output logic o_pulse
);

    // ----------------------------------------------------------
    // Source domain toggle
    // ----------------------------------------------------------

    logic r_src_toggle;

    // Each single-cycle pulse flips the level
    always_ff @(posedge i_src_clk or negedge i_src_rst_n) begin
        if (!i_src_rst_n) begin
            r_src_toggle <= 1'b0;
        end else if (i_pulse) begin
            r_src_toggle <= ~r_src_toggle;
        end
    end

    // ----------------------------------------------------------
    // Destination domain sync and edge detect
    // ----------------------------------------------------------

    // Stage 0 may go metastable, later stages settle it
    logic [SYNC_STAGES-1:0] r_sync;
    // Previous value of the settled level
    logic                   r_sync_prev;

    always_ff @(posedge i_dst_clk or negedge i_dst_rst_n) begin
        if (!i_dst_rst_n) begin
            r_sync      <= '0;
            r_sync_prev <= 1'b0;
        end else begin
            r_sync      <= {r_sync[SYNC_STAGES-2:0], r_src_toggle};
            r_sync_prev <= r_sync[SYNC_STAGES-1];
        end
    end

    // Any change of the level is one event
    assign o_pulse = r_sync[SYNC_STAGES-1] ^ r_sync_prev;

endmodule

`default_nettype wire

/* hdl/cmd_launch.sv */
// Source command launcher
`timescale 1ns/1ps
`default_nettype none

`include "cdc_consts.svh"

module cmd_launch
    import cdc_pkg::*;
(
    input  logic                   i_src_clk,
    input  logic                   i_src_rst_n,

    // User command port
    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  cdc_op_e                i_cmd_op,
    input  logic [`CDC_DATA_W-1:0] i_cmd_data,

    // Four-phase request side
    output logic                   o_req,
    output cdc_op_e                o_xfer_op,
    output logic [`CDC_DATA_W-1:0] o_xfer_data,
    input  logic                   i_ack
);

    // ----------------------------------------------------------
    // Ack synchronizer
    // ----------------------------------------------------------

    logic [`CDC_SYNC_STAGES-1:0] r_ack_sync;
    logic                        w_ack_s;

    always_ff @(posedge i_src_clk or negedge i_src_rst_n) begin
        if (!i_src_rst_n) begin
            r_ack_sync <= '0;
        end else begin
            r_ack_sync <= {r_ack_sync[`CDC_SYNC_STAGES-2:0], i_ack};
        end
    end

    // Settled ack in the source domain
    assign w_ack_s = r_ack_sync[`CDC_SYNC_STAGES-1];

    // ----------------------------------------------------------
    // Request FSM
    // ----------------------------------------------------------

    launch_state_e          r_state;
    logic                   r_req;
    // Held command, stable while req is up
    cdc_op_e                r_xfer_op;
    logic [`CDC_DATA_W-1:0] r_xfer_data;

    always_ff @(posedge i_src_clk or negedge i_src_rst_n) begin
        if (!i_src_rst_n) begin
            r_state <= L_IDLE;
            r_req   <= 1'b0;
        end else begin
            case (r_state)
                L_IDLE: begin
                    // Accept and raise req together
                    if (i_cmd_valid) begin
                        r_req   <= 1'b1;
                        r_state <= L_REQ;
                    end
                end
                L_REQ: begin
                    // Executor has taken the command
                    if (w_ack_s) begin
                        r_req   <= 1'b0;
                        r_state <= L_WAIT_ACK_LOW;
                    end
                end
                L_WAIT_ACK_LOW: begin
                    // Handshake closes once ack drops
                    if (!w_ack_s) begin
                        r_state <= L_IDLE;
                    end
                end
                default: begin
                    r_req   <= 1'b0;
                    r_state <= L_IDLE;
                end
            endcase
        end
    end

    // Payload capture on acceptance
    always_ff @(posedge i_src_clk) begin
        if (o_cmd_ready && i_cmd_valid) begin
            r_xfer_op   <= i_cmd_op;
            r_xfer_data <= i_cmd_data;
        end
    end

    assign o_cmd_ready = (r_state == L_IDLE);
    assign o_req       = r_req;
    assign o_xfer_op   = r_xfer_op;
    assign o_xfer_data = r_xfer_data;

endmodule

`default_nettype wire

/* hdl/cmd_execute.sv */
// Destination command executor
`timescale 1ns/1ps
`default_nettype none

`include "cdc_consts.svh"

module cmd_execute
    import cdc_pkg::*;
(
    input  logic                   i_dst_clk,
    input  logic                   i_dst_rst_n,

    // Four-phase acknowledge side
    input  logic                   i_req,
    input  cdc_op_e                i_xfer_op,
    input  logic [`CDC_DATA_W-1:0] i_xfer_data,
    output logic                   o_ack,

    // Synchronized event pulse
    input  logic                   i_event,

    // Results
    output logic [`CDC_DATA_W-1:0] o_result,
    output logic                   o_result_valid,
    output logic [`CDC_DATA_W-1:0] o_event_count
);

    // ----------------------------------------------------------
    // Req synchronizer
    // ----------------------------------------------------------

    logic [`CDC_SYNC_STAGES-1:0] r_req_sync;
    logic                        w_req_s;

    always_ff @(posedge i_dst_clk or negedge i_dst_rst_n) begin
        if (!i_dst_rst_n) begin
            r_req_sync <= '0;
        end else begin
            r_req_sync <= {r_req_sync[`CDC_SYNC_STAGES-2:0], i_req};
        end
    end

    assign w_req_s = r_req_sync[`CDC_SYNC_STAGES-1];

    // ----------------------------------------------------------
    // Opcode decode
    // ----------------------------------------------------------

    logic [`CDC_DATA_W-1:0] r_acc;
    logic [`CDC_DATA_W-1:0] w_acc_next;

    // Op and data are stable once req has settled high
    always_comb begin
        case (i_xfer_op)
            OP_LOAD:  w_acc_next = i_xfer_data;
            OP_ADD:   w_acc_next = r_acc + i_xfer_data;  // wraps at 2^16
            OP_XOR:   w_acc_next = r_acc ^ i_xfer_data;
            OP_CLEAR: w_acc_next = '0;
            default:  w_acc_next = r_acc;
        endcase
    end

    // ----------------------------------------------------------
    // Ack FSM and accumulator
    // ----------------------------------------------------------

    exec_state_e r_state;
    logic        r_ack;
    logic        r_result_valid;

    always_ff @(posedge i_dst_clk or negedge i_dst_rst_n) begin
        if (!i_dst_rst_n) begin
            r_state        <= E_IDLE;
            r_ack          <= 1'b0;
            r_result_valid <= 1'b0;
            r_acc          <= '0;
        end else begin
            // Result strobe lasts one cycle
            r_result_valid <= 1'b0;
            case (r_state)
                E_IDLE: begin
                    // First sight of req executes the command
                    if (w_req_s) begin
                        r_acc          <= w_acc_next;
                        r_result_valid <= 1'b1;
                        r_ack          <= 1'b1;
                        r_state        <= E_ACK;
                    end
                end
                E_ACK: begin
                    // Drop ack once the launcher releases req
                    if (!w_req_s) begin
                        r_ack   <= 1'b0;
                        r_state <= E_IDLE;
                    end
                end
                default: begin
                    r_ack   <= 1'b0;
                    r_state <= E_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Event counter
    // ----------------------------------------------------------

    logic [`CDC_DATA_W-1:0] r_event_count;

    always_ff @(posedge i_dst_clk or negedge i_dst_rst_n) begin
        if (!i_dst_rst_n) begin
            r_event_count <= '0;
        end else if (i_event) begin
            r_event_count <= r_event_count + 1'b1;
        end
    end

    assign o_ack          = r_ack;
    assign o_result       = r_acc;
    assign o_result_valid = r_result_valid;
    assign o_event_count  = r_event_count;

endmodule

`default_nettype wire

/* hdl/cdc_bridge_top.sv */
// CDC command and event bridge
`timescale 1ns/1ps
`default_nettype none

`include "cdc_consts.svh"

module cdc_bridge_top
    import cdc_pkg::*;
(
    input  logic                   i_src_clk,
    input  logic                   i_dst_clk,
    input  logic                   i_arst_n,

    // Source side commands and events
    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  cdc_op_e                i_cmd_op,
    input  logic [`CDC_DATA_W-1:0] i_cmd_data,
    input  logic                   i_event,

    // Destination side results
    output logic [`CDC_DATA_W-1:0] o_result,
    output logic                   o_result_valid,
    output logic [`CDC_DATA_W-1:0] o_event_count
);

    // ----------------------------------------------------------
    // Per-domain resets
    // ----------------------------------------------------------

    logic w_src_rst_n;
    logic w_dst_rst_n;

    reset_sync u_src_rst (
        .i_clk    (i_src_clk),
        .i_arst_n (i_arst_n),
        .o_rst_n  (w_src_rst_n)
    );

    reset_sync u_dst_rst (
        .i_clk    (i_dst_clk),
        .i_arst_n (i_arst_n),
        .o_rst_n  (w_dst_rst_n)
    );

    // ----------------------------------------------------------
    // Crossing wires
    // ----------------------------------------------------------

    logic                   w_req;
    logic                   w_ack;
    cdc_op_e                w_xfer_op;
    logic [`CDC_DATA_W-1:0] w_xfer_data;
    // Event pulse in the destination domain
    logic                   w_event_dst;

    cmd_launch u_launch (
        .i_src_clk   (i_src_clk),
        .i_src_rst_n (w_src_rst_n),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd_op    (i_cmd_op),
        .i_cmd_data  (i_cmd_data),
        .o_req       (w_req),
        .o_xfer_op   (w_xfer_op),
        .o_xfer_data (w_xfer_data),
        .i_ack       (w_ack)
    );

    sync_pulse #(
        .SYNC_STAGES (`CDC_SYNC_STAGES)
    ) u_event_sync (
        .i_src_clk   (i_src_clk),
        .i_src_rst_n (w_src_rst_n),
        .i_pulse     (i_event),
        .i_dst_clk   (i_dst_clk),
        .i_dst_rst_n (w_dst_rst_n),
        .o_pulse     (w_event_dst)
    );

    cmd_execute u_execute (
        .i_dst_clk      (i_dst_clk),
        .i_dst_rst_n    (w_dst_rst_n),
        .i_req          (w_req),
        .i_xfer_op      (w_xfer_op),
        .i_xfer_data    (w_xfer_data),
        .o_ack          (w_ack),
        .i_event        (w_event_dst),
        .o_result       (o_result),
        .o_result_valid (o_result_valid),
        .o_event_count  (o_event_count)
    );

endmodule

`default_nettype wire

/* dv/cdc_bridge_tb.sv */
// CDC bridge testbench
`timescale 1ns/1ps
`default_nettype none

`include "cdc_consts.svh"

module cdc_bridge_tb
    import cdc_pkg::*;
();

    // About 60 commands and 40 events, at most 40 dst cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int NUM_EVENTS     = 40;
    localparam int NUM_MIX        = 40;

    // ----------------------------------------------------------
    // DUT hookup
    // ----------------------------------------------------------

    logic                   src_clk;
    logic                   dst_clk;
    logic                   arst_n;
    logic                   cmd_valid;
    logic                   cmd_ready;
    cdc_op_e                cmd_op;
    logic [`CDC_DATA_W-1:0] cmd_data;
    logic                   evt;
    logic [`CDC_DATA_W-1:0] result;
    logic                   result_valid;
    logic [`CDC_DATA_W-1:0] event_count;

    cdc_bridge_top DUT (
        .i_src_clk      (src_clk),
        .i_dst_clk      (dst_clk),
        .i_arst_n       (arst_n),
        .i_cmd_valid    (cmd_valid),
        .o_cmd_ready    (cmd_ready),
        .i_cmd_op       (cmd_op),
        .i_cmd_data     (cmd_data),
        .i_event        (evt),
        .o_result       (result),
        .o_result_valid (result_valid),
        .o_event_count  (event_count)
    );

    // Unrelated clocks with 100 ns dst and 70 ns src periods
    initial begin
        src_clk = 1'b0;
        dst_clk = 1'b0;
    end
    always #50 dst_clk = ~dst_clk;
    always #35 src_clk = ~src_clk;

    // ----------------------------------------------------------
    // Bookkeeping and reference model state
    // ----------------------------------------------------------

    integer                 seed = 32'h265e_018e;
    logic [`CDC_DATA_W-1:0] model_acc;
    logic [`CDC_DATA_W-1:0] exp_q[$];
    logic [`CDC_DATA_W-1:0] exp_val;
    int                     value_errors;
    int                     protocol_errors;
    int                     accepted;
    int                     results;
    int                     cycles;
    string                  test_name;
    // Stimulus drawn up front for the parallel threads
    logic [1:0]             mix_op[NUM_MIX];
    logic [`CDC_DATA_W-1:0] mix_data[NUM_MIX];
    int                     mix_gap[NUM_MIX];
    int                     event_gap[NUM_EVENTS];

    // Result strobe is one cycle wide
    assert property (@(posedge dst_clk) disable iff (!arst_n)
                     result_valid |=> !result_valid)
    else begin
        protocol_errors++;
        $display("o_result_valid stayed high for two cycles at %0t", $time);
    end

    // Each result strobe is compared mid-cycle where outputs are settled
    always @(negedge dst_clk) begin
        if (arst_n && result_valid) begin
            results++;
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("Result pulse with no command outstanding at %0t", $time);
            end else begin
                exp_val = exp_q.pop_front();
                assert (result == exp_val) else begin
                    value_errors++;
                    $display("[FAIL] %s: expected %h actual %h", test_name, exp_val, result);
                end
            end
        end
    end

    task automatic print_counts();
        $display("Errors: %0d value, %0d protocol (commands %0d, results %0d)",
                 value_errors, protocol_errors, accepted, results);
    endtask

    // Hard stop if the handshake or a wait never completes
    always @(posedge dst_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d destination cycles",
                     TIMEOUT_CYCLES);
            print_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    task automatic check_equal(input string what, input logic [`CDC_DATA_W-1:0] exp,
                               input logic [`CDC_DATA_W-1:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("[FAIL] %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // Accumulator update for each opcode
    function automatic logic [`CDC_DATA_W-1:0] next_acc(input logic [`CDC_DATA_W-1:0] acc,
                                                        input cdc_op_e op,
                                                        input logic [`CDC_DATA_W-1:0] data);
        case (op)
            OP_LOAD:  return data;
            OP_ADD:   return acc + data;
            OP_XOR:   return acc ^ data;
            OP_CLEAR: return '0;
            default:  return acc;
        endcase
    endfunction

    // Called on a src falling edge; returns one edge after acceptance
    task automatic issue_cmd(input cdc_op_e op, input logic [`CDC_DATA_W-1:0] data);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_data  = data;
        // Ready moves only on a rising edge, stable here
        while (!cmd_ready) @(negedge src_clk);
        model_acc = next_acc(model_acc, op, data);
        exp_q.push_back(model_acc);
        accepted++;
        @(negedge src_clk);
        // Ready stays low while the handshake runs
        check_equal("o_cmd_ready after accept", '0, 16'(cmd_ready));
    endtask

    task automatic idle_cmd(input int gap);
        cmd_valid = 1'b0;
        repeat (gap) @(negedge src_clk);
    endtask

    // Ready returns only after the result strobe, so all results are in
    task automatic drain_cmds();
        cmd_valid = 1'b0;
        while (!cmd_ready) @(negedge src_clk);
        @(negedge dst_clk);
        check_equal("result count", 16'(accepted), 16'(results));
        check_equal("pending results", '0, 16'(exp_q.size()));
        check_equal("held o_result", model_acc, result);
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    initial begin
        int          i;
        int          j;
        logic [31:0] r;

        arst_n          = 1'b0;
        cmd_valid       = 1'b0;
        cmd_op          = OP_LOAD;
        cmd_data        = '0;
        evt             = 1'b0;
        model_acc       = '0;
        value_errors    = 0;
        protocol_errors = 0;
        accepted        = 0;
        results         = 0;
        cycles          = 0;
        test_name       = "reset_state";

        for (i = 0; i < NUM_MIX; i++) begin
            r           = $random(seed);
            mix_op[i]   = r[17:16];
            mix_data[i] = r[15:0];
            mix_gap[i]  = int'(r[21:20]);
        end
        // Pulse spacing of 8 to 15 src cycles
        for (i = 0; i < NUM_EVENTS; i++) begin
            r            = $random(seed);
            event_gap[i] = 7 + int'(r[2:0]);
        end

        repeat (2) @(negedge dst_clk);
        arst_n = 1'b1;
        // Let both reset synchronizers fill
        repeat (6) @(negedge dst_clk);
        check_equal("o_cmd_ready", 16'd1, 16'(cmd_ready));
        check_equal("o_result_valid", '0, 16'(result_valid));
        check_equal("o_result", '0, result);
        check_equal("o_event_count", '0, event_count);

        // Load near the top so the first add wraps
        test_name = "load_add";
        @(negedge src_clk);
        issue_cmd(OP_LOAD, 16'hfff0);
        idle_cmd(2);
        issue_cmd(OP_ADD, 16'h0025);
        idle_cmd(1);
        for (i = 0; i < 4; i++) begin
            r = $random(seed);
            issue_cmd(OP_ADD, r[15:0]);
            idle_cmd(i);
        end
        drain_cmds();

        // Clear carries a nonzero operand that must be ignored
        test_name = "xor_clear";
        @(negedge src_clk);
        issue_cmd(OP_XOR, 16'ha5a5);
        issue_cmd(OP_CLEAR, 16'hbeef);
        idle_cmd(3);
        issue_cmd(OP_XOR, 16'h0ff0);
        issue_cmd(OP_XOR, 16'h1234);
        issue_cmd(OP_CLEAR, 16'hffff);
        drain_cmds();

        // Valid never drops between commands
        test_name = "back_pressure";
        @(negedge src_clk);
        for (i = 0; i < 8; i++) begin
            r = $random(seed);
            issue_cmd(cdc_op_e'(r[17:16]), r[15:0]);
        end
        drain_cmds();

        // Events and random commands in parallel
        test_name = "random_mix";
        fork
            begin
                @(negedge src_clk);
                for (i = 0; i < NUM_EVENTS; i++) begin
                    evt = 1'b1;
                    @(negedge src_clk);
                    evt = 1'b0;
                    repeat (event_gap[i]) @(negedge src_clk);
                end
            end
            begin
                @(negedge src_clk);
                for (j = 0; j < NUM_MIX; j++) begin
                    issue_cmd(cdc_op_e'(mix_op[j]), mix_data[j]);
                    idle_cmd(mix_gap[j]);
                end
            end
        join
        drain_cmds();

        test_name = "event_crossing";
        repeat (8) @(negedge dst_clk);
        check_equal("o_event_count", 16'(NUM_EVENTS), event_count);

        print_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/cdc_pkg.sv
hdl/reset_sync.sv
hdl/sync_pulse.sv
hdl/cmd_launch.sv
hdl/cmd_execute.sv
hdl/cdc_bridge_top.sv
dv/cdc_bridge_tb.sv

/* Makefile */
# Verilator simulation of the CDC bridge

SRCS := hdl/cdc_consts.svh hdl/cdc_pkg.sv hdl/reset_sync.sv hdl/sync_pulse.sv \
        hdl/cmd_launch.sv hdl/cmd_execute.sv hdl/cdc_bridge_top.sv \
        dv/cdc_bridge_tb.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vcdc_bridge_tb: $(SRCS) sim.f
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cdc_bridge_tb

run: obj_dir/Vcdc_bridge_tb
	./obj_dir/Vcdc_bridge_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir sim.log
